// File: logic/loader_pkg.sv
// ####################
// Shared types and constants of the UART loader. BAUD_DIV is sized for short
// simulations and must be raised for real baud rates.
// ####################

package loader_pkg;

    // ####################
    // Widths
    // ####################
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [7:0]        byte_t;
    typedef logic [XLEN/8-1:0] byte_en_t;

    // ####################
    // UART and RAM sizing
    // ####################
    localparam int BAUD_DIV  = 8;                    // Clock cycles per serial bit.
    localparam int BAUD_W    = $clog2(BAUD_DIV);
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);    // Word index is addr[RAM_AW+1:2].

    // ####################
    // Host protocol
    // ####################
    localparam byte_t CMD_WRITE  = 8'h01;
    localparam byte_t CMD_READ   = 8'h02;
    localparam byte_t CMD_RUN    = 8'h03;
    localparam byte_t CMD_HALT   = 8'h04;
    localparam byte_t FAULT_CODE = 8'hFF;

    // Loader side of the RAM.
    typedef struct packed {
        logic     sel;
        xlen_t    addr;
        byte_en_t byte_en;
    } ram_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WDATA,
        ST_RD_ISSUE,
        ST_RD_SEND,
        ST_FAULT
    } loader_state_e;

endpackage

// File: logic/ram.sv
// ####################
// Word RAM. Address bits above the word index are ignored, so addresses wrap.
// ####################

module ram (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  loader_pkg::ram_req_t ram_req_i,
    input  loader_pkg::byte_t    ram_wr_data_i,
    output loader_pkg::xlen_t    ram_rd_data_o,

    input  loader_pkg::xlen_t    iram_rd_addr_i,
    output loader_pkg::xlen_t    iram_rd_data_o
);

    import loader_pkg::*;

    xlen_t             mem [RAM_WORDS];
    xlen_t             wr_word;
    logic [RAM_AW-1:0] rw_idx;
    logic [RAM_AW-1:0] if_idx;

    assign wr_word = {(XLEN / 8){ram_wr_data_i}};    // Same byte on every lane.
    assign rw_idx  = ram_req_i.addr[RAM_AW+1:2];
    assign if_idx  = iram_rd_addr_i[RAM_AW+1:2];

    // ####################
    // Loader port
    // ####################
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < XLEN / 8; i++) begin
            if (ram_req_i.sel && ram_req_i.byte_en[i]) begin
                mem[rw_idx][8*i +: 8] <= wr_word[8*i +: 8];
            end
        end
        ram_rd_data_o <= mem[rw_idx];    // Old data on a same-cycle write.
    end

    // ####################
    // Instruction fetch
    // ####################
    always_ff @(posedge clk_i) begin
        iram_rd_data_o <= mem[if_idx];
    end

    // Loader writes one byte per cycle.
    a_one_lane: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ram_req_i.sel |-> $onehot0(ram_req_i.byte_en));

endmodule

// File: logic/ram_rw.sv
// ####################
// Host command loader. Reads fetch one RAM word per returned byte, so any
// alignment works. A fault interrupts the command in progress.
// ####################

module ram_rw (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 cpu_fault_i,

    input  loader_pkg::byte_t    uart_rx_data_i,
    input  logic                 uart_rx_data_vld_i,
    output logic                 uart_rx_data_rdy_o,

    output loader_pkg::byte_t    uart_tx_data_o,
    output logic                 uart_tx_data_vld_o,
    input  logic                 uart_tx_data_rdy_i,

    input  loader_pkg::xlen_t    ram_rd_data_i,
    output loader_pkg::ram_req_t ram_req_o,

    output logic                 cpu_rst_n_o
);

    import loader_pkg::*;

    loader_state_e state;
    xlen_t         addr;
    xlen_t         cur_addr;
    logic [1:0]    byte_idx;
    logic          is_read;
    logic          fault_loaded;    // FAULT_CODE sits in the TX register.
    logic          rx_hs;
    logic          tx_hs;
    byte_t         rd_byte;

    assign rx_hs    = uart_rx_data_vld_i & uart_rx_data_rdy_o;
    assign tx_hs    = uart_tx_data_vld_o & uart_tx_data_rdy_i;
    assign cur_addr = addr + xlen_t'(byte_idx);
    assign rd_byte  = ram_rd_data_i[{cur_addr[1:0], 3'b000} +: 8];

    // Byte intake stops while a response is pending.
    assign uart_rx_data_rdy_o = (state == ST_IDLE) || (state == ST_ADDR) ||
                                (state == ST_WDATA);

    // ####################
    // RAM request
    // ####################
    always_comb begin
        ram_req_o.addr    = cur_addr;
        ram_req_o.sel     = 1'b0;
        ram_req_o.byte_en = '0;
        if (state == ST_WDATA && rx_hs) begin
            ram_req_o.sel     = 1'b1;
            ram_req_o.byte_en = byte_en_t'(1) << cur_addr[1:0];
        end else if (state == ST_RD_ISSUE) begin
            ram_req_o.sel = 1'b1;    // Read only.
        end
    end

    // ####################
    // Command FSM
    // ####################
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state              <= ST_IDLE;
            addr               <= '0;
            byte_idx           <= '0;
            is_read            <= 1'b0;
            fault_loaded       <= 1'b0;
            cpu_rst_n_o        <= 1'b0;    // CPU held until CMD_RUN.
            uart_tx_data_o     <= '0;
            uart_tx_data_vld_o <= 1'b0;
        end else if (cpu_fault_i && state != ST_FAULT) begin
            state        <= ST_FAULT;
            cpu_rst_n_o  <= 1'b0;
            fault_loaded <= 1'b0;
            if (tx_hs) begin
                uart_tx_data_vld_o <= 1'b0;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_hs) begin
                        byte_idx <= '0;
                        case (uart_rx_data_i)
                            CMD_WRITE: begin
                                is_read <= 1'b0;
                                state   <= ST_ADDR;
                            end
                            CMD_READ: begin
                                is_read <= 1'b1;
                                state   <= ST_ADDR;
                            end
                            CMD_RUN:  cpu_rst_n_o <= 1'b1;
                            CMD_HALT: cpu_rst_n_o <= 1'b0;
                            default:  ;    // Unknown byte.
                        endcase
                    end
                end
                ST_ADDR: begin
                    if (rx_hs) begin
                        addr     <= {uart_rx_data_i, addr[XLEN-1:8]};    // LSB first.
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            state <= is_read ? ST_RD_ISSUE : ST_WDATA;
                        end
                    end
                end
                ST_WDATA: begin
                    if (rx_hs) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RD_ISSUE: state <= ST_RD_SEND;
                ST_RD_SEND: begin
                    if (!uart_tx_data_vld_o) begin
                        uart_tx_data_o     <= rd_byte;
                        uart_tx_data_vld_o <= 1'b1;
                    end else if (uart_tx_data_rdy_i) begin
                        uart_tx_data_vld_o <= 1'b0;
                        byte_idx           <= byte_idx + 1'b1;
                        state              <= (byte_idx == 2'd3) ? ST_IDLE : ST_RD_ISSUE;
                    end
                end
                ST_FAULT: begin
                    // Let an interrupted response byte finish first.
                    if (!uart_tx_data_vld_o) begin
                        uart_tx_data_o     <= FAULT_CODE;
                        uart_tx_data_vld_o <= 1'b1;
                        fault_loaded       <= 1'b1;
                    end else if (uart_tx_data_rdy_i) begin
                        uart_tx_data_vld_o <= 1'b0;
                        if (fault_loaded) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_tx_vld_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        uart_tx_data_vld_o && !uart_tx_data_rdy_i |=> uart_tx_data_vld_o);

endmodule

// File: logic/soc_loader_top.sv
// ####################
// Loader subsystem. The CPU core attaches through the fetch and fault ports.
// ####################

module soc_loader_top (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              uart_rx_i,
    output logic              uart_tx_o,

    input  logic              cpu_fault_i,

    input  loader_pkg::xlen_t iram_rd_addr_i,
    output loader_pkg::xlen_t iram_rd_data_o,

    output logic              cpu_rst_n_o
);

    import loader_pkg::*;

    byte_t    uart_rx_data;
    logic     uart_rx_data_vld;
    logic     uart_rx_data_rdy;

    byte_t    uart_tx_data;
    logic     uart_tx_data_vld;
    logic     uart_tx_data_rdy;

    ram_req_t ram_req;
    xlen_t    ram_rd_data;

    uart_rx u_uart_rx (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .uart_rx_i(uart_rx_i),
        .uart_rx_data_rdy_i(uart_rx_data_rdy),
        .uart_rx_data_o(uart_rx_data),
        .uart_rx_data_vld_o(uart_rx_data_vld)
    );

    uart_tx u_uart_tx (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .uart_tx_data_i(uart_tx_data),
        .uart_tx_data_vld_i(uart_tx_data_vld),
        .uart_tx_o(uart_tx_o),
        .uart_tx_data_rdy_o(uart_tx_data_rdy)
    );

    ram_rw u_ram_rw (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .cpu_fault_i(cpu_fault_i),
        .uart_rx_data_i(uart_rx_data),
        .uart_rx_data_vld_i(uart_rx_data_vld),
        .uart_rx_data_rdy_o(uart_rx_data_rdy),
        .uart_tx_data_o(uart_tx_data),
        .uart_tx_data_vld_o(uart_tx_data_vld),
        .uart_tx_data_rdy_i(uart_tx_data_rdy),
        .ram_rd_data_i(ram_rd_data),
        .ram_req_o(ram_req),
        .cpu_rst_n_o(cpu_rst_n_o)
    );

    // Write data is the received byte itself.
    ram u_ram (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .ram_req_i(ram_req),
        .ram_wr_data_i(uart_rx_data),
        .ram_rd_data_o(ram_rd_data),
        .iram_rd_addr_i(iram_rd_addr_i),
        .iram_rd_data_o(iram_rd_data_o)
    );

endmodule

// File: logic/uart_rx.sv
// ####################
// 8N1 receiver. A byte not taken before the next frame ends is overwritten.
// ####################

module uart_rx (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              uart_rx_i,
    input  logic              uart_rx_data_rdy_i,

    output loader_pkg::byte_t uart_rx_data_o,
    output logic              uart_rx_data_vld_o
);

    import loader_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e         state;
    logic [2:0]        rx_sync;    // Two sync flops plus one for the edge.
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    byte_t             shift;
    logic              rx_line;
    logic              rx_fall;
    logic              mid_start;
    logic              mid_bit;

    assign rx_line   = rx_sync[1];
    assign rx_fall   = rx_sync[2] & ~rx_sync[1];
    assign mid_start = (baud_cnt == BAUD_W'(BAUD_DIV / 2 - 1));
    assign mid_bit   = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_sync            <= '1;
            state              <= RX_IDLE;
            baud_cnt           <= '0;
            bit_cnt            <= '0;
            uart_rx_data_vld_o <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], uart_rx_i};

            if (uart_rx_data_rdy_i) begin
                uart_rx_data_vld_o <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rx_fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (mid_start) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_line ? RX_IDLE : RX_DATA;  // Glitch, not a start bit.
                    end
                end
                RX_DATA: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (mid_bit) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (mid_bit) begin
                        state <= RX_IDLE;
                        if (rx_line) begin
                            uart_rx_data_vld_o <= 1'b1;    // Framing error drops the byte.
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path.
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && mid_bit) begin
            shift <= {rx_line, shift[7:1]};    // LSB first.
        end
        if (state == RX_STOP && mid_bit && rx_line) begin
            uart_rx_data_o <= shift;
        end
    end

    a_rx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        uart_rx_data_vld_o && !uart_rx_data_rdy_i |=> $stable(uart_rx_data_o));

endmodule

// File: logic/uart_tx.sv
// ####################
// 8N1 transmitter. Ready stays low for 10 x BAUD_DIV cycles per byte.
// ####################

module uart_tx (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  loader_pkg::byte_t uart_tx_data_i,
    input  logic              uart_tx_data_vld_i,

    output logic              uart_tx_o,
    output logic              uart_tx_data_rdy_o
);

    import loader_pkg::*;

    logic              busy;
    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;
    logic [9:0]        frame;    // Stop, data, start.

    assign uart_tx_data_rdy_o = ~busy;
    assign uart_tx_o          = frame[0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            frame    <= '1;    // Idle line.
        end else if (!busy) begin
            if (uart_tx_data_vld_i) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
                frame    <= {1'b1, uart_tx_data_i, 1'b0};
            end
        end else if (baud_cnt == BAUD_W'(BAUD_DIV - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            frame    <= {1'b1, frame[9:1]};    // Refill with idle level.
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    a_tx_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !busy |-> uart_tx_o);

endmodule

// File: test/tb_soc_loader.sv
// ####################
// Directed tests over the serial port. The testbench also stands in for the CPU
// on the fetch and fault ports. Only addresses it wrote are read back.
// ####################

module tb_soc_loader;

    timeunit 1ns;
    timeprecision 1ps;

    import loader_pkg::*;

    // Bytes on the serial line over all tests, both directions.
    localparam int TOTAL_BYTES = 176;
    localparam int MAX_CYCLES  = TOTAL_BYTES * 10 * BAUD_DIV + 1000;
    localparam int RX_WAIT     = 8 * 10 * BAUD_DIV;    // Covers a whole read command.

    logic  clk_i;
    logic  rst_n_i;
    logic  uart_rx_i;
    logic  uart_tx_o;
    logic  cpu_fault_i;
    xlen_t iram_rd_addr_i;
    xlen_t iram_rd_data_o;
    logic  cpu_rst_n_o;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    logic [15:0] lfsr;
    byte_t       model_mem [4 * RAM_WORDS];    // Byte image of the RAM.

    soc_loader_top u_soc_loader_top (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .uart_rx_i(uart_rx_i),
        .uart_tx_o(uart_tx_o),
        .cpu_fault_i(cpu_fault_i),
        .iram_rd_addr_i(iram_rd_addr_i),
        .iram_rd_data_o(iram_rd_data_o),
        .cpu_rst_n_o(cpu_rst_n_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // ####################
    // Helpers
    // ####################
    task automatic check_eq(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            v    = {v[XLEN-2:0], lfsr[15]};
            lfsr = {lfsr[14:0], fb};
        end
        return v;
    endfunction

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_i);
            uart_rx_i = frame[i];
            repeat (BAUD_DIV - 1) @(negedge clk_i);
        end
    endtask

    task automatic recv_byte(output byte_t b);
        int waited;
        b      = '0;
        waited = 0;
        @(negedge clk_i);
        while (uart_tx_o !== 1'b0 && waited < RX_WAIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (uart_tx_o !== 1'b0) begin
            $display("error: no start bit on uart_tx_o within %0d cycles", RX_WAIT);
            errors++;
        end else begin
            repeat (BAUD_DIV / 2) @(negedge clk_i);    // Mid start bit.
            check_eq("uart_tx_o start bit", uart_tx_o, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge clk_i);
                b[i] = uart_tx_o;
            end
            repeat (BAUD_DIV) @(negedge clk_i);
            check_eq("uart_tx_o stop bit", uart_tx_o, 1'b1);
        end
    endtask

    task automatic write_word(input xlen_t addr, input xlen_t data);
        logic [RAM_AW+1:0] idx;
        send_byte(CMD_WRITE);
        for (int i = 0; i < 4; i++) begin
            send_byte(addr[8*i +: 8]);
        end
        for (int i = 0; i < 4; i++) begin
            send_byte(data[8*i +: 8]);
            idx            = addr[RAM_AW+1:0] + (RAM_AW + 2)'(i);    // Wraps.
            model_mem[idx] = data[8*i +: 8];
        end
    endtask

    task automatic read_word(input xlen_t addr, output xlen_t word);
        byte_t b;
        word = '0;
        fork
            begin
                send_byte(CMD_READ);
                for (int i = 0; i < 4; i++) begin
                    send_byte(addr[8*i +: 8]);
                end
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    recv_byte(b);
                    word[8*i +: 8] = b;    // LSB first.
                end
            end
        join
    endtask

    function automatic xlen_t model_word(input xlen_t addr);
        xlen_t             w;
        logic [RAM_AW+1:0] idx;
        for (int i = 0; i < 4; i++) begin
            idx          = addr[RAM_AW+1:0] + (RAM_AW + 2)'(i);
            w[8*i +: 8]  = model_mem[idx];
        end
        return w;
    endfunction

    task automatic wait_cpu_rst(input logic exp);
        int n;
        n = 0;
        while (cpu_rst_n_o !== exp && n < 4 * BAUD_DIV) begin
            @(negedge clk_i);
            n++;
        end
        check_eq("cpu_rst_n_o", cpu_rst_n_o, exp);
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
        end
        $display("%-16s %s", name, (errors == err0) ? "ok" : "FAIL");
    endtask

    // ####################
    // Tests
    // ####################
    task automatic test_reset_state();
        int err0;
        err0 = errors;
        check_eq("uart_tx_o", uart_tx_o, 1'b1);
        check_eq("cpu_rst_n_o", cpu_rst_n_o, 1'b0);
        end_test("reset_state", err0);
    endtask

    task automatic test_write_read();
        int    err0;
        xlen_t word;
        err0 = errors;
        write_word(32'h0000_0010, 32'hA5C3_1E78);
        read_word(32'h0000_0010, word);
        check_eq("read word", word, 32'hA5C3_1E78);
        end_test("write_read", err0);
    endtask

    task automatic test_ifetch();
        int err0;
        err0 = errors;
        @(negedge clk_i);
        iram_rd_addr_i = 32'h0000_0010;
        @(negedge clk_i);
        check_eq("iram_rd_data_o", iram_rd_data_o, 32'hA5C3_1E78);
        iram_rd_addr_i = 32'h0000_0014;    // Unwritten word in between.
        @(negedge clk_i);
        iram_rd_addr_i = 32'h0000_0010 + 4 * RAM_WORDS;    // Aliases the same word.
        @(negedge clk_i);
        check_eq("iram_rd_data_o wrapped", iram_rd_data_o, 32'hA5C3_1E78);
        end_test("ifetch", err0);
    endtask

    task automatic test_reset_ctrl();
        int    err0;
        xlen_t word;
        err0 = errors;
        send_byte(CMD_RUN);
        wait_cpu_rst(1'b1);
        send_byte(8'h5A);
        repeat (2 * BAUD_DIV) @(negedge clk_i);
        check_eq("cpu_rst_n_o after unknown", cpu_rst_n_o, 1'b1);
        send_byte(CMD_HALT);
        wait_cpu_rst(1'b0);
        read_word(32'h0000_0010, word);
        check_eq("read word", word, 32'hA5C3_1E78);
        end_test("reset_ctrl", err0);
    endtask

    task automatic test_fault();
        int    err0;
        byte_t b;
        err0 = errors;
        send_byte(CMD_RUN);
        wait_cpu_rst(1'b1);
        @(negedge clk_i);
        cpu_fault_i = 1'b1;
        @(negedge clk_i);
        cpu_fault_i = 1'b0;
        recv_byte(b);
        check_eq("fault byte", b, FAULT_CODE);
        check_eq("cpu_rst_n_o", cpu_rst_n_o, 1'b0);
        end_test("fault", err0);
    endtask

    task automatic test_random();
        int    err0;
        xlen_t addrs [8];
        xlen_t data;
        xlen_t word;
        err0 = errors;
        // Low bits in a 32-byte window, so words overlap.
        for (int k = 0; k < 8; k++) begin
            addrs[k] = (rand_bits(32) & 32'hFFFF_FC1F) | 32'h0000_0040;
            data     = rand_bits(32);
            write_word(addrs[k], data);
        end
        for (int k = 0; k < 8; k++) begin
            read_word(addrs[k], word);
            check_eq("random read word", word, model_word(addrs[k]));
        end
        end_test("random", err0);
    endtask

    // ####################
    // Main sequence
    // ####################
    initial begin
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        lfsr           = 16'd27;
        rst_n_i        = 1'b0;
        uart_rx_i      = 1'b1;
        cpu_fault_i    = 1'b0;
        iram_rd_addr_i = '0;
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        test_reset_state();
        test_write_read();
        test_ifetch();
        test_reset_ctrl();
        test_fault();
        test_random();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/loader_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/ram.sv
logic/ram_rw.sv
logic/soc_loader_top.sv
test/tb_soc_loader.sv
